// File: Bender.yml
package:
  name: tof_hist

export_include_dirs:
  - .

sources:
  - files:
      - tof_event_pkg.sv
      - tof_hist_pkg.sv
      - stream_fifo.sv
      - hist_builder.sv
      - hist_peak_finder.sv
      - tof_hist_top.sv
  - target: test
    files:
      - tof_hist_chk.sv
      - tb_tof_hist.sv

// File: all.f
+incdir+.
tof_event_pkg.sv
tof_hist_pkg.sv
stream_fifo.sv
hist_builder.sv
hist_peak_finder.sv
tof_hist_top.sv
tof_hist_chk.sv
tb_tof_hist.sv

// File: hist_builder.sv
`timescale 1ns/1ps
`include "tof_cfg.svh"

module hist_builder (
    input  logic                       clk,
    input  logic                       res,
    input  tof_event_pkg::tof_event_t  ev,
    input  logic                       ev_valid,
    output logic                       ev_ready,
    output logic                       bank_full,
    output tof_hist_pkg::tof_bank_t    full_bank,
    input  logic                       scan_en,
    input  tof_hist_pkg::tof_scan_t    scan_addr,
    output tof_hist_pkg::tof_count_t   scan_count,
    input  logic                       scan_done
);
    localparam int ADDR_W = `TOF_PIX_W + `TOF_BIN_W;
    localparam int LOCS   = `TOF_PIXELS * `TOF_BINS;
    localparam int ACQ_W  = (`TOF_ACQS > 1) ? $clog2(`TOF_ACQS) : 1;

    // two banks of pixel x bin counters
    tof_hist_pkg::tof_count_t mem [2][LOCS];

    // sequential clear after reset
    logic                     clr_busy;
    logic [ADDR_W-1:0]        clr_addr;

    // bank being filled and acquisition position
    tof_hist_pkg::tof_bank_t  act_bank;
    tof_hist_pkg::tof_bank_t  scan_bank;
    logic [ACQ_W-1:0]         acq_cnt;
    logic                     acq_wrap;
    // histogram done but other bank still busy
    logic                     stall;

    logic                     ev_fire;
    logic                     hist_end;
    logic [ADDR_W-1:0]        ev_addr;
    tof_hist_pkg::tof_count_t ev_cur;
    tof_hist_pkg::tof_count_t ev_sum;

    assign ev_ready  = !clr_busy && !stall;
    assign ev_fire   = ev_valid && ev_ready;
    assign acq_wrap  = (acq_cnt == ACQ_W'(`TOF_ACQS - 1));
    assign hist_end  = ev_fire && ev.last_of_acq && acq_wrap;
    // scans always go to the bank not being filled
    assign scan_bank = ~act_bank;

    // flat location index, pixel major
    assign ev_addr = {ev.pixel, ev.bin};
    assign ev_cur  = mem[act_bank][ev_addr];
    // hold at all ones instead of wrapping
    assign ev_sum  = (ev_cur == '1) ? ev_cur : ev_cur + 1'b1;

    // count storage, clear, accumulate and read-and-clear
    always_ff @(posedge clk) begin
        if (clr_busy) begin
            mem[0][clr_addr] <= '0;
            mem[1][clr_addr] <= '0;
        end else begin
            if (ev_fire) begin
                mem[act_bank][ev_addr] <= ev_sum;
            end
            // never the same bank as the event write
            if (scan_en) begin
                mem[scan_bank][scan_addr] <= '0;
            end
        end
        // count shows up one cycle after the request
        if (scan_en) begin
            scan_count <= mem[scan_bank][scan_addr];
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clr_busy  <= 1'b1;
            clr_addr  <= '0;
            act_bank  <= 1'b0;
            acq_cnt   <= '0;
            stall     <= 1'b0;
            bank_full <= 1'b0;
            full_bank <= 1'b0;
        end else begin
            // walk every location once after reset
            if (clr_busy) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == ADDR_W'(LOCS - 1)) begin
                    clr_busy <= 1'b0;
                end
            end

            if (ev_fire && ev.last_of_acq) begin
                acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
            end

            if (stall) begin
                // finder released the other bank, swap now
                if (scan_done) begin
                    act_bank  <= ~act_bank;
                    full_bank <= act_bank;
                    bank_full <= 1'b1;
                    stall     <= 1'b0;
                end
            end else if (hist_end) begin
                // a scan ending on this edge frees the bank too
                if (bank_full && !scan_done) begin
                    stall <= 1'b1;
                end else begin
                    act_bank  <= ~act_bank;
                    full_bank <= act_bank;
                    bank_full <= 1'b1;
                end
            end else if (scan_done) begin
                bank_full <= 1'b0;
            end
        end
    end

endmodule

// File: hist_peak_finder.sv
`timescale 1ns/1ps
`include "tof_cfg.svh"

module hist_peak_finder (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     bank_full,
    input  tof_hist_pkg::tof_bank_t  full_bank,
    output logic                     scan_en,
    output tof_hist_pkg::tof_scan_t  scan_addr,
    input  tof_hist_pkg::tof_count_t scan_count,
    output logic                     scan_done,
    output tof_hist_pkg::tof_peak_t  pk,
    output logic                     pk_valid,
    input  logic                     pk_ready
);
    localparam int PIX_W = `TOF_PIX_W;
    localparam int BIN_W = `TOF_BIN_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_PRESENT
    } state_t;

    state_t                   state;
    logic [PIX_W-1:0]         pix;
    logic [BIN_W-1:0]         bin;
    // read issued last cycle, count arrives now
    logic                     rd_pend;
    logic [BIN_W-1:0]         rd_bin;

    // running search for the current pixel
    tof_hist_pkg::tof_count_t max_cnt;
    logic [BIN_W-1:0]         max_bin;
    tof_hist_pkg::tof_total_t total;

    // search state with the arriving count folded in
    tof_hist_pkg::tof_count_t fold_max;
    logic [BIN_W-1:0]         fold_bin;
    tof_hist_pkg::tof_total_t fold_total;

    logic                     last_pix;
    logic                     pk_fire;
    logic                     pix_start;

    assign scan_en   = (state == S_SCAN);
    assign scan_addr = '{pixel: pix, bin: bin};
    assign last_pix  = (pix == PIX_W'(`TOF_PIXELS - 1));
    assign pk_valid  = (state == S_PRESENT);
    assign pk_fire   = pk_valid && pk_ready;
    // idle, or moving on to the next pixel
    assign pix_start = (state == S_IDLE) || (pk_fire && !last_pix);

    // strict compare so the lower bin keeps a tie
    always_comb begin
        fold_max   = max_cnt;
        fold_bin   = max_bin;
        fold_total = total;
        if (rd_pend) begin
            fold_total = total + tof_hist_pkg::tof_total_t'(scan_count);
            if (scan_count > max_cnt) begin
                fold_max = scan_count;
                fold_bin = rd_bin;
            end
        end
    end

    // first present cycle folds bin 15 on the fly, stable afterwards
    assign pk = '{bank: full_bank, pixel: pix, peak_bin: fold_bin,
                  peak_count: fold_max, total: fold_total};

    always_ff @(posedge clk) begin
        if (scan_en) begin
            rd_bin <= bin;
        end
        if (pix_start) begin
            max_cnt <= '0;
            max_bin <= '0;
            total   <= '0;
        end else if (rd_pend) begin
            max_cnt <= fold_max;
            max_bin <= fold_bin;
            total   <= fold_total;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= S_IDLE;
            pix       <= '0;
            bin       <= '0;
            rd_pend   <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            rd_pend   <= scan_en;
            scan_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    // bank_full is stale while scan_done is high
                    if (bank_full && !scan_done) begin
                        state <= S_SCAN;
                        pix   <= '0;
                        bin   <= '0;
                    end
                end
                S_SCAN: begin
                    bin <= bin + 1'b1;
                    if (bin == BIN_W'(`TOF_BINS - 1)) begin
                        state <= S_PRESENT;
                    end
                end
                S_PRESENT: begin
                    // wait here while the output is blocked
                    if (pk_ready) begin
                        if (last_pix) begin
                            state     <= S_IDLE;
                            scan_done <= 1'b1;
                        end else begin
                            state <= S_SCAN;
                            pix   <= pix + 1'b1;
                            bin   <= '0;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: stream_fifo.sv
`timescale 1ns/1ps
`include "tof_cfg.svh"

module stream_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     res,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);
    localparam int DEPTH = `TOF_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             push;
    logic             pop;

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // blocked only when every entry is taken
    assign in_ready  = (fill != CNT_W'(DEPTH));
    assign out_valid = (fill != '0);
    // head entry straight from storage
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // simultaneous push and pop keeps the level
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
        end
    end

endmodule

// File: tb_tof_hist.sv
`timescale 1ns/1ps
`include "tof_cfg.svh"

module tb_tof_hist;
    localparam int CLK_PERIOD  = 100;
    localparam int CNT_MAX     = (1 << `TOF_CNT_W) - 1;
    // read cycles plus present cycle per pixel, small slack
    localparam int SCAN_CYCLES = `TOF_PIXELS * (`TOF_BINS + 1) + 4;
    // events and histograms over all tests, rounded up
    localparam int MAX_EVENTS  = 1100;
    localparam int MAX_HISTS   = 11;
    localparam int RUN_CYCLES  = 3 * (5 + `TOF_PIXELS * `TOF_BINS + MAX_EVENTS
                                      + MAX_HISTS * SCAN_CYCLES);

    logic                      clk;
    logic                      res;
    tof_event_pkg::tof_event_t evt;
    logic                      evt_valid;
    logic                      evt_ready;
    tof_hist_pkg::tof_peak_t   peak;
    logic                      peak_valid;
    logic                      peak_ready;

    int                        errors;
    string                     test_name;
    logic [31:0]               lcg_state;
    logic                      stim_done;
    // bank tag of the next histogram
    logic                      exp_bank;
    // reference counts of the histogram being sent
    int                        model [`TOF_PIXELS][`TOF_BINS];
    tof_event_pkg::tof_event_t ev_q [$];
    tof_hist_pkg::tof_peak_t   exp_q [$];

    tof_hist_top DUT (
        .clk        (clk),
        .res        (res),
        .evt        (evt),
        .evt_valid  (evt_valid),
        .evt_ready  (evt_ready),
        .peak       (peak),
        .peak_valid (peak_valid),
        .peak_ready (peak_ready)
    );

    bind tof_hist_top tof_hist_chk u_chk (
        .clk        (clk),
        .res        (res),
        .evt        (evt),
        .evt_valid  (evt_valid),
        .evt_ready  (evt_ready),
        .peak       (peak),
        .peak_valid (peak_valid),
        .peak_ready (peak_ready),
        .bank_full  (bank_full),
        .scan_done  (scan_done)
    );

    initial begin
        clk = 1'b0;
    end
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch in %s, %s: expected %0d, actual %0d",
                     test_name, field, expected, actual);
        end
    endtask

    task automatic compare_result(input tof_hist_pkg::tof_peak_t exp_r,
                                  input tof_hist_pkg::tof_peak_t got);
        string tag;
        tag = $sformatf("pixel %0d", exp_r.pixel);
        check_value({tag, " bank"}, exp_r.bank, got.bank);
        check_value({tag, " index"}, exp_r.pixel, got.pixel);
        check_value({tag, " peak_bin"}, exp_r.peak_bin, got.peak_bin);
        check_value({tag, " peak_count"}, exp_r.peak_count, got.peak_count);
        check_value({tag, " total"}, exp_r.total, got.total);
    endtask

    // results sampled mid cycle, the transfer lands on the next rising edge
    always @(negedge clk) begin
        if (res && peak_valid && peak_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("error in %s: result for pixel %0d arrived with none expected",
                         test_name, peak.pixel);
            end else begin
                compare_result(exp_q.pop_front(), peak);
            end
        end
    end

    task automatic queue_events(input int pixel, input int bin, input int n);
        tof_event_pkg::tof_event_t e;
        e.pixel       = `TOF_PIX_W'(pixel);
        e.bin         = `TOF_BIN_W'(bin);
        e.last_of_acq = 1'b0;
        repeat (n) begin
            ev_q.push_back(e);
        end
    endtask

    // flag the newest queued event as end of acquisition
    task automatic end_acq();
        tof_event_pkg::tof_event_t e;
        e = ev_q.pop_back();
        e.last_of_acq = 1'b1;
        ev_q.push_back(e);
    endtask

    // called 1 ns after a rising edge, returns the same way
    task automatic send_event(input tof_event_pkg::tof_event_t e);
        evt       = e;
        evt_valid = 1'b1;
        @(negedge clk);
        while (!evt_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        evt_valid = 1'b0;
    endtask

    // peak is lowest bin holding the maximum, total is the plain sum
    task automatic push_expected();
        tof_hist_pkg::tof_peak_t r;
        int best;
        int sum;
        int p;
        int b;
        for (p = 0; p < `TOF_PIXELS; p++) begin
            best       = 0;
            sum        = 0;
            r.peak_bin = '0;
            for (b = 0; b < `TOF_BINS; b++) begin
                sum += model[p][b];
                if (model[p][b] > best) begin
                    best       = model[p][b];
                    r.peak_bin = `TOF_BIN_W'(b);
                end
                model[p][b] = 0;
            end
            r.bank       = exp_bank;
            r.pixel      = `TOF_PIX_W'(p);
            r.peak_count = `TOF_CNT_W'(best);
            r.total      = `TOF_TOT_W'(sum);
            exp_q.push_back(r);
        end
        exp_bank = ~exp_bank;
    endtask

    // one histogram, as many events as make up the acquisitions
    task automatic run_hist();
        tof_event_pkg::tof_event_t e;
        int acqs;
        acqs = 0;
        while (acqs < `TOF_ACQS) begin
            e = ev_q.pop_front();
            send_event(e);
            // saturating reference count
            if (model[e.pixel][e.bin] < CNT_MAX) begin
                model[e.pixel][e.bin]++;
            end
            if (e.last_of_acq) begin
                acqs++;
            end
        end
        push_expected();
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < 8 * SCAN_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("error in %s: %0d results never arrived", test_name, exp_q.size());
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_single_peak();
        int a;
        int p;
        test_name = "single_peak";
        for (a = 0; a < `TOF_ACQS; a++) begin
            for (p = 0; p < `TOF_PIXELS; p++) begin
                // distinct peak bin per pixel plus a smaller neighbour
                queue_events(p, 3 * p + 1, 2 + p);
                queue_events(p, 3 * p + 2, 1);
            end
            end_acq();
        end
        run_hist();
        wait_results();
    endtask

    task automatic test_tie_and_empty();
        int a;
        test_name = "tie_and_empty";
        for (a = 0; a < `TOF_ACQS; a++) begin
            // higher bin sent first, lower one must still win
            queue_events(0, 9, 3);
            queue_events(0, 5, 3);
            queue_events(1, 12, 2);
            queue_events(1, 2, 2);
            queue_events(1, 0, 1);
            queue_events(3, 15, 1);
            queue_events(3, 14, 1);
            // pixel 2 gets nothing
            end_acq();
        end
        run_hist();
        wait_results();
    endtask

    task automatic test_saturation();
        int a;
        test_name = "saturation";
        for (a = 0; a < `TOF_ACQS; a++) begin
            // 300 into one bin, 320 into another
            queue_events(1, 6, 75);
            queue_events(1, 7, 3);
            queue_events(3, 0, 80);
            end_acq();
        end
        run_hist();
        wait_results();
    endtask

    task automatic test_ping_pong();
        int a;
        int p;
        test_name = "ping_pong";
        for (a = 0; a < `TOF_ACQS; a++) begin
            for (p = 0; p < `TOF_PIXELS; p++) begin
                queue_events(p, p, 5);
            end
            end_acq();
        end
        // second histogram avoids pixel 0 and the first bins
        for (a = 0; a < `TOF_ACQS; a++) begin
            for (p = 1; p < `TOF_PIXELS; p++) begin
                queue_events(p, 15 - p, 2);
            end
            end_acq();
        end
        run_hist();
        run_hist();
        wait_results();
    endtask

    task automatic test_back_pressure();
        int h;
        int a;
        int p;
        logic blocked;
        test_name = "back_pressure";
        for (h = 0; h < 3; h++) begin
            for (a = 0; a < `TOF_ACQS; a++) begin
                for (p = 0; p < `TOF_PIXELS; p++) begin
                    queue_events(p, (5 * h + p) % `TOF_BINS, 1);
                end
                end_acq();
            end
        end
        peak_ready = 1'b0;
        stim_done  = 1'b0;
        blocked    = 1'b0;
        fork
            begin
                repeat (3) begin
                    run_hist();
                end
                stim_done = 1'b1;
            end
            begin
                // both banks busy, so the input side has to block
                while (!stim_done) begin
                    @(negedge clk);
                    if (!evt_ready) begin
                        blocked = 1'b1;
                    end
                end
            end
        join
        // finder runs into the full output fifo and waits there
        repeat (SCAN_CYCLES) begin
            @(posedge clk);
        end
        #1;
        if (!blocked) begin
            errors++;
            $display("error in %s: evt_ready never dropped under back-pressure",
                     test_name);
        end
        peak_ready = 1'b1;
        wait_results();
    endtask

    task automatic test_random_stream();
        logic [31:0] r;
        int h;
        int a;
        int n;
        int i;
        test_name = "random_stream";
        // all events drawn before the run starts
        for (h = 0; h < 3; h++) begin
            for (a = 0; a < `TOF_ACQS; a++) begin
                r = lcg_next();
                n = 1 + int'(r[27:24]) % 12;
                for (i = 0; i < n; i++) begin
                    r = lcg_next();
                    queue_events(r[17:16], r[23:20], 1);
                end
                end_acq();
            end
        end
        stim_done = 1'b0;
        fork
            begin
                repeat (3) begin
                    run_hist();
                end
                stim_done = 1'b1;
            end
            begin
                while (!stim_done) begin
                    @(posedge clk);
                    #1;
                    r          = lcg_next();
                    peak_ready = r[24];
                end
            end
        join
        peak_ready = 1'b1;
        wait_results();
    endtask

    // stops a hung run
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        errors++;
        $display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
        $display("errors: %0d", errors);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        errors     = 0;
        test_name  = "reset";
        lcg_state  = 32'h2f89fac7;
        exp_bank   = 1'b0;
        stim_done  = 1'b0;
        res        = 1'b0;
        evt        = '0;
        evt_valid  = 1'b0;
        peak_ready = 1'b1;
        repeat (5) begin
            @(posedge clk);
        end
        #1;
        res = 1'b1;
        @(negedge clk);
        check_value("evt_ready after reset", 1, evt_ready);
        check_value("peak_valid after reset", 0, peak_valid);
        @(posedge clk);
        #1;

        test_single_peak();
        test_tie_and_empty();
        test_saturation();
        test_ping_pong();
        test_back_pressure();
        test_random_stream();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tof_cfg.svh
`ifndef TOF_CFG_SVH
`define TOF_CFG_SVH

// time bin index width, 16 bins per pixel
`define TOF_BIN_W 4
`define TOF_BINS (1 << `TOF_BIN_W)

// pixel index width and pixel count
`define TOF_PIX_W 2
`define TOF_PIXELS (1 << `TOF_PIX_W)

// acquisitions summed into one histogram
`define TOF_ACQS 4

// one bin count saturates at 255
`define TOF_CNT_W 8
// pixel total, holds 16 bins of 255
`define TOF_TOT_W 12

// entries in each stream buffer
`define TOF_FIFO_DEPTH 4

`endif

// File: tof_event_pkg.sv
`include "tof_cfg.svh"

package tof_event_pkg;

    // one photon event from the tdc front end
    typedef struct packed {
        logic [`TOF_PIX_W-1:0] pixel;
        logic [`TOF_BIN_W-1:0] bin;
        // marks end of one acquisition
        logic                  last_of_acq;
    } tof_event_t;

endpackage

// File: tof_hist_chk.sv
`timescale 1ns/1ps

module tof_hist_chk (
    input logic                      clk,
    input logic                      res,
    input tof_event_pkg::tof_event_t evt,
    input logic                      evt_valid,
    input logic                      evt_ready,
    input tof_hist_pkg::tof_peak_t   peak,
    input logic                      peak_valid,
    input logic                      peak_ready,
    input logic                      bank_full,
    input logic                      scan_done
);

    // event word held until the input fifo takes it
    evt_hold: assert property (@(posedge clk) disable iff (!res)
        evt_valid && !evt_ready |=> evt_valid && $stable(evt))
        else $error("evt changed or dropped while evt_ready was low");

    // result word held until the sink takes it
    peak_hold: assert property (@(posedge clk) disable iff (!res)
        peak_valid && !peak_ready |=> peak_valid && $stable(peak))
        else $error("peak changed or dropped while peak_ready was low");

    // output stays quiet right after reset release
    peak_quiet: assert property (@(posedge clk)
        $rose(res) |-> !peak_valid ##1 !peak_valid)
        else $error("peak_valid high within one cycle after reset");

    // scan can only finish on a full bank
    scan_in_bank: assert property (@(posedge clk) disable iff (!res)
        scan_done |-> bank_full)
        else $error("scan_done pulsed while bank_full was low");

endmodule

// File: tof_hist_pkg.sv
`include "tof_cfg.svh"

package tof_hist_pkg;

    // ping-pong bank select
    typedef logic tof_bank_t;

    // single bin count and per-pixel sum
    typedef logic [`TOF_CNT_W-1:0] tof_count_t;
    typedef logic [`TOF_TOT_W-1:0] tof_total_t;

    // scan address, pixel in the upper bits
    typedef struct packed {
        logic [`TOF_PIX_W-1:0] pixel;
        logic [`TOF_BIN_W-1:0] bin;
    } tof_scan_t;

    // one result word per pixel
    typedef struct packed {
        tof_bank_t             bank;
        logic [`TOF_PIX_W-1:0] pixel;
        logic [`TOF_BIN_W-1:0] peak_bin;
        tof_count_t            peak_count;
        tof_total_t            total;
    } tof_peak_t;

endpackage

// File: tof_hist_top.sv
`timescale 1ns/1ps

module tof_hist_top (
    input  logic                      clk,
    input  logic                      res,
    input  tof_event_pkg::tof_event_t evt,
    input  logic                      evt_valid,
    output logic                      evt_ready,
    output tof_hist_pkg::tof_peak_t   peak,
    output logic                      peak_valid,
    input  logic                      peak_ready
);
    // event fifo to builder
    tof_event_pkg::tof_event_t ev;
    logic                      ev_valid;
    logic                      ev_ready;

    // builder and finder handshake
    logic                      bank_full;
    tof_hist_pkg::tof_bank_t   full_bank;
    logic                      scan_en;
    tof_hist_pkg::tof_scan_t   scan_addr;
    tof_hist_pkg::tof_count_t  scan_count;
    logic                      scan_done;

    // finder to peak fifo
    tof_hist_pkg::tof_peak_t   pk;
    logic                      pk_valid;
    logic                      pk_ready;

    stream_fifo #(
        .payload_t(tof_event_pkg::tof_event_t)
    ) u_evt_fifo (
        .clk       (clk),
        .res       (res),
        .in_data   (evt),
        .in_valid  (evt_valid),
        .in_ready  (evt_ready),
        .out_data  (ev),
        .out_valid (ev_valid),
        .out_ready (ev_ready)
    );

    hist_builder u_builder (
        .clk        (clk),
        .res        (res),
        .ev         (ev),
        .ev_valid   (ev_valid),
        .ev_ready   (ev_ready),
        .bank_full  (bank_full),
        .full_bank  (full_bank),
        .scan_en    (scan_en),
        .scan_addr  (scan_addr),
        .scan_count (scan_count),
        .scan_done  (scan_done)
    );

    hist_peak_finder u_finder (
        .clk        (clk),
        .res        (res),
        .bank_full  (bank_full),
        .full_bank  (full_bank),
        .scan_en    (scan_en),
        .scan_addr  (scan_addr),
        .scan_count (scan_count),
        .scan_done  (scan_done),
        .pk         (pk),
        .pk_valid   (pk_valid),
        .pk_ready   (pk_ready)
    );

    stream_fifo #(
        .payload_t(tof_hist_pkg::tof_peak_t)
    ) u_peak_fifo (
        .clk       (clk),
        .res       (res),
        .in_data   (pk),
        .in_valid  (pk_valid),
        .in_ready  (pk_ready),
        .out_data  (peak),
        .out_valid (peak_valid),
        .out_ready (peak_ready)
    );

endmodule
